// ==== Makefile ====
TOOL       ?= verilator
TOP        ?= tb_periph_xbar
FLIST      ?= periph_xbar.f
FLAGS      ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG    = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_periph_xbar.sv ====
// Peripheral crossbar testbench top
// Clock and reset, LFSR driven masters with one request in flight each,
// and slave models with a small memory that answer one cycle after a transfer

`default_nettype none

`include "periph_xbar_config.svh"

module tb_periph_xbar;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_PER_MASTER = 40;                            // Requests per master
    localparam int N_TRANS      = N_PER_MASTER * `PX_N_MASTER;
    localparam int CYCLE_LIMIT  = 40 * N_TRANS;

    logic                                          clk;
    logic                                          arst_n_i;
    logic [`PX_N_MASTER-1:0]                       data_req_i;
    logic [`PX_N_MASTER-1:0][`PX_ADDR_W-1:0]       data_add_i;
    logic [`PX_N_MASTER-1:0]                       data_wen_i;
    logic [`PX_N_MASTER-1:0][`PX_DATA_W-1:0]       data_wdata_i;
    logic [`PX_N_MASTER-1:0][`PX_BE_W-1:0]         data_be_i;
    logic [`PX_N_MASTER-1:0]                       data_gnt_o;
    logic [`PX_N_MASTER-1:0]                       data_r_valid_o;
    logic [`PX_N_MASTER-1:0][`PX_DATA_W-1:0]       data_r_rdata_o;
    logic [`PX_N_MASTER-1:0]                       data_r_opc_o;
    logic [`PX_N_SLAVE-1:0]                        data_req_o;
    logic [`PX_N_SLAVE-1:0][`PX_WADDR_W-1:0]       data_add_o;
    logic [`PX_N_SLAVE-1:0]                        data_wen_o;
    logic [`PX_N_SLAVE-1:0][`PX_DATA_W-1:0]        data_wdata_o;
    logic [`PX_N_SLAVE-1:0][`PX_BE_W-1:0]          data_be_o;
    logic [`PX_N_SLAVE-1:0][`PX_N_MASTER-1:0]      data_ID_o;
    logic [`PX_N_SLAVE-1:0]                        data_gnt_i;
    logic [`PX_N_SLAVE-1:0]                        data_r_valid_i;
    logic [`PX_N_SLAVE-1:0][`PX_DATA_W-1:0]        data_r_rdata_i;
    logic [`PX_N_SLAVE-1:0][`PX_N_MASTER-1:0]      data_r_id_i;
    logic [`PX_N_SLAVE-1:0]                        data_r_opc_i;
    int                                            value_errs_o;   // From the checker
    int                                            other_errs_o;

    logic [15:0]             lfsr_q;                         // Galois LFSR state
    logic [`PX_N_MASTER-1:0] wait_resp;                      // Transfer done, response due
    int                      issued   [`PX_N_MASTER];
    int                      done_cnt [`PX_N_MASTER];
    logic [`PX_DATA_W-1:0]   slave_mem [`PX_N_SLAVE][16];    // 16 words per slave
    int                      cycle_cnt;

    // One LFSR step per bit taken, newest bit lands in bit 0
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // Start pattern over slave and word
    function automatic logic [31:0] fill_word(input int s, input int w);
        return {8'(s), 8'(w), 8'(8'hC3 ^ (s * 16 + w)), 8'(~w)};
    endfunction

    function automatic int total_done();
        int sum;
        sum = 0;
        for (int m = 0; m < `PX_N_MASTER; m++)
            sum += done_cnt[m];
        return sum;
    endfunction

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    periph_xbar UUT (.*);

    xbar_checker i_xbar_checker (.*);

    //////////////////////////////////////////////////
    // Reset, run control and summary
    //////////////////////////////////////////////////

    initial
    begin
        lfsr_q         = 16'd81;
        data_req_i     = '0;
        data_add_i     = '0;
        data_wen_i     = '0;
        data_wdata_i   = '0;
        data_be_i      = '0;
        data_gnt_i     = '0;
        data_r_valid_i = '0;
        data_r_rdata_i = '0;
        data_r_id_i    = '0;
        data_r_opc_i   = '0;
        wait_resp      = '0;
        cycle_cnt      = 0;
        for (int m = 0; m < `PX_N_MASTER; m++)
        begin
            issued[m]   = 0;
            done_cnt[m] = 0;
        end
        for (int s = 0; s < `PX_N_SLAVE; s++)
            for (int w = 0; w < 16; w++)
                slave_mem[s][w] = fill_word(s, w);
        arst_n_i = 1'b0;
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        while (total_done() < N_TRANS && cycle_cnt < CYCLE_LIMIT)
            @(negedge clk);
        repeat (2) @(negedge clk);  // Let the last response be checked
        if (total_done() < N_TRANS)
            $display("Cycle limit of %0d reached with transactions still open", CYCLE_LIMIT);
        $display("Summary: %0d value errors, %0d other errors, %0d of %0d transactions done",
                 value_errs_o, other_errs_o, total_done(), N_TRANS);
        if (total_done() == N_TRANS && value_errs_o == 0 && other_errs_o == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Master and slave models
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin : drive_models
        logic [31:0] r;
        logic [31:0] add;
        int          w;
        cycle_cnt = cycle_cnt + 1;
        if (arst_n_i)
        begin
            for (int m = 0; m < `PX_N_MASTER; m++)
            begin
                if (data_req_i[m] && data_gnt_o[m])
                begin
                    data_req_i[m] <= 1'b0;  // Transferred
                    wait_resp[m]   = 1'b1;
                end
                else if (wait_resp[m] && data_r_valid_o[m])
                begin
                    wait_resp[m] = 1'b0;
                    done_cnt[m]++;
                end
                else if (!data_req_i[m] && !wait_resp[m] && issued[m] < N_PER_MASTER)
                begin
                    r = rand_bits(1);
                    if (r[0])
                    begin
                        add = '0;
                        r   = rand_bits(3);
                        if (r[2:0] == 3'd0)
                        begin
                            r          = rand_bits(14);
                            add[31:18] = r[13:0];  // About one in eight tagged
                        end
                        r               = rand_bits(8);
                        add[17:16]      = r[7:6];   // Slave select
                        add[5:2]        = r[5:2];   // Word within 16
                        add[1:0]        = r[1:0];
                        data_add_i[m]   <= add;
                        r               = rand_bits(1);
                        data_wen_i[m]   <= r[0];
                        data_wdata_i[m] <= rand_bits(32);
                        r               = rand_bits(4);
                        data_be_i[m]    <= r[3:0];
                        data_req_i[m]   <= 1'b1;
                        issued[m]++;
                    end
                end
            end
            for (int s = 0; s < `PX_N_SLAVE; s++)
            begin
                data_r_valid_i[s] <= 1'b0;
                if (data_req_o[s] && data_gnt_i[s])
                begin
                    w = int'(data_add_o[s][3:0]);
                    if (data_wen_o[s])
                        data_r_rdata_i[s] <= slave_mem[s][w];
                    else
                    begin
                        for (int b = 0; b < `PX_BE_W; b++)
                            if (data_be_o[s][b])
                                slave_mem[s][w][8*b +: 8] = data_wdata_o[s][8*b +: 8];
                        data_r_rdata_i[s] <= '0;
                    end
                    data_r_valid_i[s] <= 1'b1;
                    data_r_id_i[s]    <= data_ID_o[s];      // Echo
                    data_r_opc_i[s]   <= |data_add_o[s][29:16];  // Error on nonzero tag
                end
                r = rand_bits(2);
                data_gnt_i[s] <= (r[1:0] != 2'b00);  // Ready three times in four
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/xbar_checker.sv ====
// Crossbar checker
// Watches both sides of the DUT, keeps its own round-robin pointers and a
// reference memory per slave, and counts mismatches

`default_nettype none

`include "periph_xbar_config.svh"

module xbar_checker (
    input  wire logic                                      clk,
    input  wire logic                                      arst_n_i,
    input  wire logic [`PX_N_MASTER-1:0]                   data_req_i,
    input  wire logic [`PX_N_MASTER-1:0][`PX_ADDR_W-1:0]   data_add_i,
    input  wire logic [`PX_N_MASTER-1:0]                   data_wen_i,
    input  wire logic [`PX_N_MASTER-1:0][`PX_DATA_W-1:0]   data_wdata_i,
    input  wire logic [`PX_N_MASTER-1:0][`PX_BE_W-1:0]     data_be_i,
    input  wire logic [`PX_N_MASTER-1:0]                   data_gnt_o,
    input  wire logic [`PX_N_MASTER-1:0]                   data_r_valid_o,
    input  wire logic [`PX_N_MASTER-1:0][`PX_DATA_W-1:0]   data_r_rdata_o,
    input  wire logic [`PX_N_MASTER-1:0]                   data_r_opc_o,
    input  wire logic [`PX_N_SLAVE-1:0]                    data_req_o,
    input  wire logic [`PX_N_SLAVE-1:0][`PX_WADDR_W-1:0]   data_add_o,
    input  wire logic [`PX_N_SLAVE-1:0]                    data_wen_o,
    input  wire logic [`PX_N_SLAVE-1:0][`PX_DATA_W-1:0]    data_wdata_o,
    input  wire logic [`PX_N_SLAVE-1:0][`PX_BE_W-1:0]      data_be_o,
    input  wire logic [`PX_N_SLAVE-1:0][`PX_N_MASTER-1:0]  data_ID_o,
    input  wire logic [`PX_N_SLAVE-1:0]                    data_gnt_i,
    output int                                             value_errs_o,
    output int                                             other_errs_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int                      ptr [`PX_N_SLAVE];             // Model priority pointers
    logic [`PX_DATA_W-1:0]   ref_mem [`PX_N_SLAVE][16];
    logic [`PX_N_MASTER-1:0] exp_valid;                     // Response due this cycle
    logic [`PX_N_MASTER-1:0] exp_opc;
    logic [`PX_N_MASTER-1:0] exp_load;
    logic [`PX_DATA_W-1:0]   exp_rdata [`PX_N_MASTER];
    int                      passed [`PX_N_MASTER];         // Transfers to others while waiting
    logic                    seen_req;

    initial
    begin
        value_errs_o = 0;
        other_errs_o = 0;
        seen_req     = 1'b0;
        exp_valid    = '0;
        for (int m = 0; m < `PX_N_MASTER; m++)
            passed[m] = 0;
        for (int s = 0; s < `PX_N_SLAVE; s++)
            for (int w = 0; w < 16; w++)
                ref_mem[s][w] = {8'(s), 8'(w), 8'(8'hC3 ^ (s * 16 + w)), 8'(~w)};
    end

    task automatic report_value(input string test, input logic [71:0] exp,
                                input logic [71:0] act);
        $display("ERR %s expected %0h actual %0h", test, exp, act);
        value_errs_o++;
    endtask

    task automatic report_fault(input string what);
        $display("%s", what);
        other_errs_o++;
    endtask

    always @(posedge clk)
    begin : compare
        logic [`PX_N_MASTER-1:0] req_here;
        logic [`PX_N_MASTER-1:0] exp_gnt;
        logic [`PX_N_MASTER-1:0] next_valid;
        int                      win;
        int                      c;
        int                      w;
        int                      tgt;
        if (arst_n_i && |data_req_i)
            seen_req = 1'b1;
        // Quiet until the first request
        if ((!arst_n_i || !seen_req) && (|data_gnt_o || |data_req_o || |data_r_valid_o))
            report_fault("Grant, slave request or response valid high before any request");
        if (!arst_n_i)
        begin
            for (int s = 0; s < `PX_N_SLAVE; s++)
                ptr[s] = 0;
            for (int m = 0; m < `PX_N_MASTER; m++)
                passed[m] = 0;
            exp_valid = '0;
        end
        else
        begin
            // Responses one cycle after the grant
            for (int m = 0; m < `PX_N_MASTER; m++)
            begin
                if (data_r_valid_o[m] !== exp_valid[m])
                    report_value($sformatf("resp_valid m%0d", m), 72'(exp_valid[m]),
                                 72'(data_r_valid_o[m]));
                else if (exp_valid[m])
                begin
                    if (data_r_opc_o[m] !== exp_opc[m])
                        report_value($sformatf("resp_opc m%0d", m), 72'(exp_opc[m]),
                                     72'(data_r_opc_o[m]));
                    if (exp_load[m] && data_r_rdata_o[m] !== exp_rdata[m])
                        report_value($sformatf("resp_rdata m%0d", m), 72'(exp_rdata[m]),
                                     72'(data_r_rdata_o[m]));
                end
            end
            // A waiting master loses its slave to each other master at most once
            for (int m = 0; m < `PX_N_MASTER; m++)
            begin
                tgt = int'(data_add_i[m][`PX_ROUTE_LSB +: `PX_SEL_W]);
                if (data_req_i[m] && !data_gnt_o[m])
                begin
                    if (data_req_o[tgt] && data_gnt_i[tgt])
                    begin
                        passed[m]++;
                        if (passed[m] == `PX_N_MASTER)
                            report_fault($sformatf("Master %0d passed over %0d times at slave %0d",
                                                   m, passed[m], tgt));
                    end
                end
                else
                    passed[m] = 0;
            end
            //////////////////////////////////////////////////
            // Round-robin model and routing
            //////////////////////////////////////////////////
            exp_gnt    = '0;
            next_valid = '0;
            for (int s = 0; s < `PX_N_SLAVE; s++)
            begin
                for (int m = 0; m < `PX_N_MASTER; m++)
                    req_here[m] = data_req_i[m] &&
                                  (int'(data_add_i[m][`PX_ROUTE_LSB +: `PX_SEL_W]) == s);
                win = -1;
                for (int k = 0; k < `PX_N_MASTER; k++)
                begin
                    c = (ptr[s] + k) % `PX_N_MASTER;  // Upward from the pointer
                    if (win < 0 && req_here[c])
                        win = c;
                end
                if (data_req_o[s] !== (win >= 0))
                    report_value($sformatf("slave_req s%0d", s), 72'(win >= 0),
                                 72'(data_req_o[s]));
                else if (win >= 0)
                begin
                    // Word address, payload and one-hot ID of the winner
                    if ({data_add_o[s], data_wen_o[s], data_wdata_o[s], data_be_o[s],
                         data_ID_o[s]} !== {data_add_i[win][31:2], data_wen_i[win],
                         data_wdata_i[win], data_be_i[win], 4'(1 << win)})
                        report_value($sformatf("route s%0d", s),
                                     72'({data_add_i[win][31:2], data_wen_i[win],
                                          data_wdata_i[win], data_be_i[win], 4'(1 << win)}),
                                     72'({data_add_o[s], data_wen_o[s], data_wdata_o[s],
                                          data_be_o[s], data_ID_o[s]}));
                    if (data_gnt_i[s])
                    begin
                        exp_gnt[win]    = 1'b1;
                        next_valid[win] = 1'b1;
                        w               = int'(data_add_i[win][5:2]);
                        exp_load[win]   = data_wen_i[win];
                        exp_opc[win]    = |data_add_i[win][31:18];
                        exp_rdata[win]  = ref_mem[s][w];
                        if (!data_wen_i[win])
                            for (int b = 0; b < `PX_BE_W; b++)
                                if (data_be_i[win][b])
                                    ref_mem[s][w][8*b +: 8] = data_wdata_i[win][8*b +: 8];
                        ptr[s] = (win + 1) % `PX_N_MASTER;
                    end
                end
            end
            for (int m = 0; m < `PX_N_MASTER; m++)
                if (data_gnt_o[m] !== exp_gnt[m])
                    report_value($sformatf("grant m%0d", m), 72'(exp_gnt[m]),
                                 72'(data_gnt_o[m]));
            exp_valid = next_valid;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pe_addr_decoder.sv ====
// Master address decoder
// Picks the target slave from the address select field, strips the byte
// offset, stamps the one-hot master ID and folds slave grants into one

`default_nettype none

`include "periph_xbar_config.svh"

module pe_addr_decoder #(
    parameter int MASTER_IDX = 0
) (
    input  wire logic                     data_req_i,
    input  periph_xbar_pkg::pe_addr_u     data_add_i,
    input  wire logic [`PX_N_SLAVE-1:0]   slave_gnt_i,   // From the arbiter
    output logic [`PX_N_SLAVE-1:0]        slave_req_o,   // One bit per slave
    output periph_xbar_pkg::word_addr_t   word_add_o,
    output logic                          data_gnt_o,
    output periph_xbar_pkg::master_id_t   data_id_o
);

    // Exactly one slave targeted while requesting
    always_comb
    begin
        slave_req_o = '0;
        if (data_req_i)
        begin
            slave_req_o[data_add_i.fld.slave_sel] = 1'b1;
        end
    end

    // Word address from the raw view, byte offset dropped
    assign word_add_o = data_add_i.raw[`PX_ADDR_W-1:`PX_ADDR_W-`PX_WADDR_W];

    assign data_id_o  = periph_xbar_pkg::master_id_t'(1) << MASTER_IDX;  // One-hot ID

    // Grant only counts from the slave we target
    assign data_gnt_o = |(slave_gnt_i & slave_req_o);

endmodule

`default_nettype wire

// ==== hdl/periph_xbar.sv ====
// Peripheral crossbar top level
// Address decoders per master, one round-robin arbiter for all slaves,
// a request mux per slave and a response router per master

`default_nettype none

`include "periph_xbar_config.svh"

module periph_xbar (
    input  wire logic                                               clk,
    input  wire logic                                               arst_n_i,
    // Master side
    input  wire logic [`PX_N_MASTER-1:0]                            data_req_i,
    input  wire logic [`PX_N_MASTER-1:0][`PX_ADDR_W-1:0]            data_add_i,
    input  wire logic [`PX_N_MASTER-1:0]                            data_wen_i,   // 1 is load
    input  periph_xbar_pkg::data_t [`PX_N_MASTER-1:0]               data_wdata_i,
    input  periph_xbar_pkg::be_t   [`PX_N_MASTER-1:0]               data_be_i,
    output logic [`PX_N_MASTER-1:0]                                 data_gnt_o,
    output logic [`PX_N_MASTER-1:0]                                 data_r_valid_o,
    output periph_xbar_pkg::data_t [`PX_N_MASTER-1:0]               data_r_rdata_o,
    output logic [`PX_N_MASTER-1:0]                                 data_r_opc_o, // Error
    // Slave side
    output logic [`PX_N_SLAVE-1:0]                                  data_req_o,
    output periph_xbar_pkg::word_addr_t [`PX_N_SLAVE-1:0]           data_add_o,
    output logic [`PX_N_SLAVE-1:0]                                  data_wen_o,
    output periph_xbar_pkg::data_t [`PX_N_SLAVE-1:0]                data_wdata_o,
    output periph_xbar_pkg::be_t   [`PX_N_SLAVE-1:0]                data_be_o,
    output periph_xbar_pkg::master_id_t [`PX_N_SLAVE-1:0]           data_ID_o,
    input  wire logic [`PX_N_SLAVE-1:0]                             data_gnt_i,
    input  wire logic [`PX_N_SLAVE-1:0]                             data_r_valid_i,
    input  periph_xbar_pkg::data_t [`PX_N_SLAVE-1:0]                data_r_rdata_i,
    input  periph_xbar_pkg::master_id_t [`PX_N_SLAVE-1:0]           data_r_id_i,  // Echoed ID
    input  wire logic [`PX_N_SLAVE-1:0]                             data_r_opc_i
);

    logic [`PX_N_MASTER-1:0][`PX_N_SLAVE-1:0]        dec_req;     // Master major
    logic [`PX_N_SLAVE-1:0][`PX_N_MASTER-1:0]        arb_req;     // Slave major
    logic [`PX_N_MASTER-1:0][`PX_N_SLAVE-1:0]        master_gnt;  // Grants back to decoders
    periph_xbar_pkg::word_addr_t [`PX_N_MASTER-1:0]  word_add;
    periph_xbar_pkg::master_id_t [`PX_N_MASTER-1:0]  master_id;
    periph_xbar_pkg::master_id_t [`PX_N_SLAVE-1:0]   arb_choice;  // Winner per slave

    //////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////

    for (genvar m = 0; m < `PX_N_MASTER; m++) begin : g_master
        pe_addr_decoder #(
            .MASTER_IDX ( m )
        ) i_pe_addr_decoder (
            .data_req_i  ( data_req_i[m] ),
            .data_add_i  ( data_add_i[m] ),
            .slave_gnt_i ( master_gnt[m] ),
            .slave_req_o ( dec_req[m]    ),
            .word_add_o  ( word_add[m]   ),
            .data_gnt_o  ( data_gnt_o[m] ),
            .data_id_o   ( master_id[m]  )
        );

        for (genvar s = 0; s < `PX_N_SLAVE; s++) begin : g_xpose
            assign arb_req[s][m] = dec_req[m][s];  // Transpose for the arbiter
        end
    end

    slave_arbiter i_slave_arbiter (
        .clk          ( clk        ),
        .arst_n_i     ( arst_n_i   ),
        .slave_req_i  ( arb_req    ),
        .data_gnt_i   ( data_gnt_i ),
        .choice_o     ( arb_choice ),
        .master_gnt_o ( master_gnt )
    );

    for (genvar s = 0; s < `PX_N_SLAVE; s++) begin : g_slave
        request_mux i_request_mux (
            .choice_i     ( arb_choice[s]   ),
            .word_add_i   ( word_add        ),
            .data_wen_i   ( data_wen_i      ),
            .data_wdata_i ( data_wdata_i    ),
            .data_be_i    ( data_be_i       ),
            .data_id_i    ( master_id       ),
            .data_req_o   ( data_req_o[s]   ),
            .data_add_o   ( data_add_o[s]   ),
            .data_wen_o   ( data_wen_o[s]   ),
            .data_wdata_o ( data_wdata_o[s] ),
            .data_be_o    ( data_be_o[s]    ),
            .data_ID_o    ( data_ID_o[s]    )
        );
    end

    //////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////

    for (genvar m = 0; m < `PX_N_MASTER; m++) begin : g_resp
        response_router #(
            .MASTER_IDX ( m )
        ) i_response_router (
            .data_r_valid_i ( data_r_valid_i    ),
            .data_r_id_i    ( data_r_id_i       ),
            .data_r_rdata_i ( data_r_rdata_i    ),
            .data_r_opc_i   ( data_r_opc_i      ),
            .data_r_valid_o ( data_r_valid_o[m] ),
            .data_r_rdata_o ( data_r_rdata_o[m] ),
            .data_r_opc_o   ( data_r_opc_o[m]   )
        );
    end

endmodule

`default_nettype wire

// ==== hdl/periph_xbar_pkg.sv ====
// Peripheral crossbar types
// Address layout as a union of the raw word and its routing fields,
// plus the word types shared by the request and response paths

`default_nettype none

`include "periph_xbar_config.svh"

package periph_xbar_pkg;

    typedef logic [`PX_SEL_W-1:0]    slave_sel_t;   // Slave index
    typedef logic [`PX_N_MASTER-1:0] master_id_t;   // One-hot master ID
    typedef logic [`PX_WADDR_W-1:0]  word_addr_t;   // Address as a slave sees it
    typedef logic [`PX_DATA_W-1:0]   data_t;
    typedef logic [`PX_BE_W-1:0]     be_t;

    // Routing view of the 32-bit master address
    typedef struct packed {
        logic [`PX_ADDR_W-`PX_ROUTE_LSB-`PX_SEL_W-1:0]   tag;        // Upper tag, 31:18
        slave_sel_t                                      slave_sel;  // 17:16
        logic [`PX_ROUTE_LSB-(`PX_ADDR_W-`PX_WADDR_W)-1:0] slave_off; // 15:2
        logic [`PX_ADDR_W-`PX_WADDR_W-1:0]               byte_off;   // 1:0
    } pe_addr_fields_t;

    // Same word, raw or split into fields
    typedef union packed {
        logic [`PX_ADDR_W-1:0] raw;
        pe_addr_fields_t       fld;
    } pe_addr_u;

endpackage

`default_nettype wire

// ==== hdl/request_mux.sv ====
// Slave request mux
// Forwards the fields of the master chosen by the arbiter to one slave
// port, request is raised whenever a master is chosen

`default_nettype none

`include "periph_xbar_config.svh"

module request_mux (
    input  periph_xbar_pkg::master_id_t                     choice_i,  // One-hot or zero
    input  periph_xbar_pkg::word_addr_t [`PX_N_MASTER-1:0]  word_add_i,
    input  wire logic [`PX_N_MASTER-1:0]                    data_wen_i,
    input  periph_xbar_pkg::data_t [`PX_N_MASTER-1:0]       data_wdata_i,
    input  periph_xbar_pkg::be_t   [`PX_N_MASTER-1:0]       data_be_i,
    input  periph_xbar_pkg::master_id_t [`PX_N_MASTER-1:0]  data_id_i,  // From the decoders
    output logic                                            data_req_o,
    output periph_xbar_pkg::word_addr_t                     data_add_o,
    output logic                                            data_wen_o,
    output periph_xbar_pkg::data_t                          data_wdata_o,
    output periph_xbar_pkg::be_t                            data_be_o,
    output periph_xbar_pkg::master_id_t                     data_ID_o
);

    // Plain select, fields are zero when nobody is chosen
    always_comb
    begin
        data_add_o   = '0;
        data_wen_o   = 1'b0;
        data_wdata_o = '0;
        data_be_o    = '0;
        data_ID_o    = '0;
        for (int m = 0; m < `PX_N_MASTER; m++)
        begin
            if (choice_i[m])
            begin
                data_add_o   = word_add_i[m];
                data_wen_o   = data_wen_i[m];
                data_wdata_o = data_wdata_i[m];
                data_be_o    = data_be_i[m];
                data_ID_o    = data_id_i[m];  // Same bit as the choice
            end
        end
    end

    assign data_req_o = |choice_i;

endmodule

`default_nettype wire

// ==== hdl/response_router.sv ====
// Response router for one master
// Picks the slave whose valid response carries this master's ID bit and
// forwards its read data and error flag

`default_nettype none

`include "periph_xbar_config.svh"

module response_router #(
    parameter int MASTER_IDX = 0
) (
    input  wire logic [`PX_N_SLAVE-1:0]                     data_r_valid_i,
    input  periph_xbar_pkg::master_id_t [`PX_N_SLAVE-1:0]   data_r_id_i,
    input  periph_xbar_pkg::data_t [`PX_N_SLAVE-1:0]        data_r_rdata_i,
    input  wire logic [`PX_N_SLAVE-1:0]                     data_r_opc_i,
    output logic                                            data_r_valid_o,
    output periph_xbar_pkg::data_t                          data_r_rdata_o,
    output logic                                            data_r_opc_o
);

    logic [`PX_N_SLAVE-1:0] hit;  // Valid response addressed to us

    for (genvar s = 0; s < `PX_N_SLAVE; s++) begin : g_hit
        assign hit[s] = data_r_valid_i[s] & data_r_id_i[s][MASTER_IDX];
    end

    assign data_r_valid_o = |hit;

    // One outstanding request per master, so at most one hit
    always_comb
    begin
        data_r_rdata_o = '0;
        data_r_opc_o   = 1'b0;
        for (int s = 0; s < `PX_N_SLAVE; s++)
        begin
            if (hit[s])
            begin
                data_r_rdata_o = data_r_rdata_i[s];
                data_r_opc_o   = data_r_opc_i[s];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/slave_arbiter.sv ====
// Round-robin arbiter for all slaves
// One priority pointer per slave, winner is the first requester at or
// above the pointer with wrap, grant is qualified by the slave grant

`default_nettype none

`include "periph_xbar_config.svh"

module slave_arbiter (
    input  wire logic                                          clk,
    input  wire logic                                          arst_n_i,
    input  wire logic [`PX_N_SLAVE-1:0][`PX_N_MASTER-1:0]      slave_req_i,
    input  wire logic [`PX_N_SLAVE-1:0]                        data_gnt_i,   // Slave ready
    output periph_xbar_pkg::master_id_t [`PX_N_SLAVE-1:0]      choice_o,     // One-hot winner
    output logic [`PX_N_MASTER-1:0][`PX_N_SLAVE-1:0]           master_gnt_o
);

    localparam int MIDX_W = $clog2(`PX_N_MASTER);  // Master index width

    for (genvar s = 0; s < `PX_N_SLAVE; s++) begin : g_slave
        logic [MIDX_W-1:0] ptr_q;     // Highest priority master
        logic [MIDX_W-1:0] win_idx;
        logic              win_vld;   // Some master requests this slave

        //////////////////////////////////////////////////
        // Winner search
        //////////////////////////////////////////////////

        // Scan downward so the nearest requester above the pointer is kept
        always_comb
        begin
            int unsigned cand;
            win_idx = ptr_q;
            win_vld = 1'b0;
            for (int k = `PX_N_MASTER - 1; k >= 0; k--)
            begin
                cand = (int'(ptr_q) + k) % `PX_N_MASTER;  // Wrap around
                if (slave_req_i[s][cand])
                begin
                    win_idx = MIDX_W'(cand);
                    win_vld = 1'b1;
                end
            end
        end

        assign choice_o[s] = win_vld ? (periph_xbar_pkg::master_id_t'(1) << win_idx) : '0;

        // Pointer moves past the winner only on a real transfer
        always_ff @(posedge clk or negedge arst_n_i)
        begin
            if (!arst_n_i)
            begin
                ptr_q <= '0;  // Master 0 first
            end
            else if (win_vld && data_gnt_i[s])
            begin
                ptr_q <= MIDX_W'((int'(win_idx) + 1) % `PX_N_MASTER);
            end
        end

        // Grant matrix, master major for the decoders
        for (genvar m = 0; m < `PX_N_MASTER; m++) begin : g_gnt
            assign master_gnt_o[m][s] = choice_o[s][m] & data_gnt_i[s];
        end
    end

endmodule

`default_nettype wire

// ==== include/periph_xbar_config.svh ====
// Peripheral crossbar configuration
// Master and slave counts, bus widths and the position of the
// slave select field inside the master address

`ifndef PERIPH_XBAR_CONFIG_SVH
`define PERIPH_XBAR_CONFIG_SVH

`define PX_N_MASTER   4                  // Cores on the request side
`define PX_N_SLAVE    4                  // Peripheral ports

`define PX_ADDR_W     32                 // Master byte address
`define PX_DATA_W     32
`define PX_BE_W       (`PX_DATA_W / 8)   // One enable per byte lane

// Slave select field, address bits 17:16
`define PX_ROUTE_LSB  16
`define PX_SEL_W      2

// Word address seen by a slave, address bits 31:2
`define PX_WADDR_W    30

`endif

// ==== periph_xbar.f ====
+incdir+include
hdl/periph_xbar_pkg.sv
hdl/pe_addr_decoder.sv
hdl/slave_arbiter.sv
hdl/request_mux.sv
hdl/response_router.sv
hdl/periph_xbar.sv
dv/xbar_checker.sv
dv/tb_periph_xbar.sv
